/* list.f */
+incdir+include
hw/read_datapath_pkg.sv
hw/read_valid_gen.sv
hw/oct_ctrl.sv
hw/read_datapath.sv
tb/tb_clk_gen.sv
tb/tb_read_datapath.sv

/* Bender.yml */
package:
  name: read_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/read_datapath_pkg.sv
      - hw/read_valid_gen.sv
      - hw/oct_ctrl.sv
      - hw/read_datapath.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_read_datapath.sv

/* tb/tb_read_datapath.sv */
//**************************************************************************
// Read datapath testbench
// Applies a table of latency, burst, OCT and data rows and checks the
// valid strobe, the OCT window and the slot-ordered read data
//**************************************************************************

`timescale 1ns/1ps

`include "read_datapath_defs.svh"

module tb_read_datapath
	import read_datapath_pkg::*;
;

	localparam int NUM_ROWS       = 8;
	localparam int ROW_CYCLES     = 48;
	// Rows never run past 60 cycles, doubled for margin plus the reset phase
	localparam int MAX_ROW_CYCLES = 60;
	localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS * MAX_ROW_CYCLES + 40;

	// OCT window in edges after the request, MEM_T_RL of 8
	localparam int OCT_FIRST = 2;
	localparam int OCT_LAST  = 7;

	logic       pll_afi_clk;
	logic       reset_n_afi_clk;

	afi_phase_t afi_rdata_en;
	afi_phase_t afi_rdata_en_full;
	lat_count_t seq_read_latency_counter;
	afi_data_t  ddio_phy_dq;
	afi_data_t  afi_rdata;
	afi_phase_t afi_rdata_valid;
	oct_ctrl_t  force_oct_off;

	//**********************************************************************
	// Stimulus table
	//**********************************************************************

	// Columns are latency, burst length, OCT mode, random data words,
	// expected valid cycles and expected OCT low cycles
	// OCT mode 0 is no pulse, 1 is one pulse, 2 is two pulses 3 apart
	int row_latency   [NUM_ROWS];
	int row_burst     [NUM_ROWS];
	int row_oct_mode  [NUM_ROWS];
	int row_data_cnt  [NUM_ROWS];
	int row_exp_valid [NUM_ROWS];
	int row_exp_oct   [NUM_ROWS];

	// Expected events, indexed by the number of edges since reset release
	bit exp_valid_mark [0:1023];
	bit exp_oct_mark   [0:1023];

	int        edge_cnt;
	int        cycle_cnt;
	int        err_cnt;
	int        check_cnt;
	int        row_valid_cnt;
	int        row_oct_cnt;
	integer    seed;
	afi_data_t dq_drv;

	tb_clk_gen tb_clk_gen_i
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk)
	);

	read_datapath read_datapath_i
	(
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en),
		.afi_rdata_en_full_i        (afi_rdata_en_full),
		.seq_read_latency_counter_i (seq_read_latency_counter),
		.ddio_phy_dq_i              (ddio_phy_dq),
		.afi_rdata_o                (afi_rdata),
		.afi_rdata_valid_o          (afi_rdata_valid),
		.force_oct_off_o            (force_oct_off)
	);

	// Edge 1 is the first rising edge with reset released
	always @(posedge pll_afi_clk)
	begin
		if (reset_n_afi_clk)
			edge_cnt <= edge_cnt + 1;
	end

	// Ends the run if the row loop stalls
	always @(posedge pll_afi_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the rows did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	//**********************************************************************
	// Expected data and compare tasks
	//**********************************************************************

	// Beat t of group g comes from bits 32g+8t up and goes to bits 16t+8g up
	function automatic afi_data_t slot_order(input afi_data_t dq);
		afi_data_t res;
		res = '0;
		for (int t = 0; t < `NUM_TIMESLOTS; t++)
			for (int g = 0; g < `MEM_READ_DQS_WIDTH; g++)
				for (int b = 0; b < `DQ_GROUP_WIDTH; b++)
					res[16 * t + 8 * g + b] = dq[32 * g + 8 * t + b];
		return res;
	endfunction

	task automatic check_data(input string name, input afi_data_t got, input afi_data_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("error: %s got 0x%h expected 0x%h after edge %0d", name, got, exp, edge_cnt);
		end
	endtask

	task automatic check_valid(input string name, input afi_phase_t got, input afi_phase_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("error: %s got 0x%h expected 0x%h after edge %0d", name, got, exp, edge_cnt);
		end
	endtask

	task automatic check_oct(input string name, input oct_ctrl_t got, input oct_ctrl_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("error: %s got 0x%h expected 0x%h after edge %0d", name, got, exp, edge_cnt);
		end
	endtask

	task automatic add_row(input int lat, input int burst, input int oct_mode,
		input int data_cnt, input int exp_valid, input int exp_oct, input int idx);
		row_latency[idx]   = lat;
		row_burst[idx]     = burst;
		row_oct_mode[idx]  = oct_mode;
		row_data_cnt[idx]  = data_cnt;
		row_exp_valid[idx] = exp_valid;
		row_exp_oct[idx]   = exp_oct;
	endtask

	// Compares both strobes after the edges counted so far
	task automatic check_outputs();
		afi_phase_t exp_v;
		oct_ctrl_t  exp_o;
		exp_v = exp_valid_mark[edge_cnt] ? 2'b11 : 2'b00;
		// Before the first edge the OCT register still holds its reset value
		if (edge_cnt == 0 || exp_oct_mark[edge_cnt])
			exp_o = '0;
		else
			exp_o = {`AFI_DQS_WIDTH{1'b1}};
		check_valid("afi_rdata_valid", afi_rdata_valid, exp_v);
		check_oct("force_oct_off", force_oct_off, exp_o);
		if (afi_rdata_valid == 2'b11)
			row_valid_cnt++;
		if (edge_cnt > 0 && force_oct_off == '0)
			row_oct_cnt++;
	endtask

	// Drives cycle cyc of a row and marks what the next edge will cause
	task automatic drive_inputs(input int row, input int cyc);
		logic req;
		logic oct_req;
		int   n;
		req = (cyc >= 1) && (cyc <= row_burst[row]);
		oct_req = (row_oct_mode[row] >= 1 && cyc == 1) || (row_oct_mode[row] == 2 && cyc == 4);
		if (cyc < row_data_cnt[row])
			dq_drv = {$random(seed), $random(seed)};
		else
			dq_drv = '0;
		seq_read_latency_counter = row_latency[row];
		afi_rdata_en             = {2{req}};
		afi_rdata_en_full        = {2{oct_req}};
		ddio_phy_dq              = dq_drv;
		// The coming rising edge samples these inputs
		n = edge_cnt + 1;
		if (req)
			exp_valid_mark[n + row_latency[row] + 2] = 1'b1;
		if (oct_req)
			for (int k = OCT_FIRST; k <= OCT_LAST; k++)
				exp_oct_mark[n + k] = 1'b1;
	endtask

	//**********************************************************************
	// Main sequence
	//**********************************************************************

	initial
	begin
		edge_cnt                 = 0;
		cycle_cnt                = 0;
		err_cnt                  = 0;
		check_cnt                = 0;
		seed                     = 29;
		dq_drv                   = '0;
		afi_rdata_en             = '0;
		afi_rdata_en_full        = '0;
		seq_read_latency_counter = '0;
		ddio_phy_dq              = '0;

		// Idle row first, then single requests at each latency, then bursts
		add_row(0,  0, 0, 4,  0, 0, 0);
		add_row(0,  1, 1, 8,  1, 6, 1);
		add_row(3,  1, 0, 8,  1, 0, 2);
		add_row(7,  1, 2, 8,  1, 9, 3);
		add_row(31, 1, 1, 8,  1, 6, 4);
		add_row(3,  4, 0, 16, 4, 0, 5);
		add_row(31, 3, 2, 16, 3, 9, 6);
		add_row(7,  2, 1, 32, 2, 6, 7);

		// Both strobes must sit at zero while reset is held
		@(negedge pll_afi_clk);
		while (!reset_n_afi_clk)
		begin
			check_valid("afi_rdata_valid", afi_rdata_valid, '0);
			check_oct("force_oct_off", force_oct_off, '0);
			@(negedge pll_afi_clk);
		end

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			int row_err_start;
			row_err_start = err_cnt;
			row_valid_cnt = 0;
			row_oct_cnt   = 0;
			for (int c = 0; c < ROW_CYCLES; c++)
			begin
				check_outputs();
				drive_inputs(r, c);
				// Read data has no register, so it must follow before the next edge
				#1;
				check_data("afi_rdata", afi_rdata, slot_order(dq_drv));
				@(negedge pll_afi_clk);
			end
			if (row_valid_cnt != row_exp_valid[r])
			begin
				err_cnt++;
				$display("row %0d gave %0d read valid cycles instead of %0d",
					r, row_valid_cnt, row_exp_valid[r]);
			end
			if (row_oct_cnt != row_exp_oct[r])
			begin
				err_cnt++;
				$display("row %0d held OCT off for %0d cycles instead of %0d",
					r, row_oct_cnt, row_exp_oct[r]);
			end
			$display("row %0d latency %0d burst %0d: %0d valid, %0d oct low, %0d errors",
				r, row_latency[r], row_burst[r], row_valid_cnt, row_oct_cnt,
				err_cnt - row_err_start);
		end

		// Outputs after the last driven cycle
		check_outputs();

		$display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* tb/tb_clk_gen.sv */
//**************************************************************************
// Testbench clock and reset
// Runs the AFI clock at 4 ns and holds reset low for three cycles
//**************************************************************************

`timescale 1ns/1ps

module tb_clk_gen
(
	output logic pll_afi_clk,
	output logic reset_n_afi_clk
);

	// Free running AFI clock, 250 MHz
	initial
	begin
		pll_afi_clk = 1'b0;
		forever
		begin
			#2 pll_afi_clk = ~pll_afi_clk;
		end
	end

	// Release lands between edges so no flop sees it together with a clock edge
	initial
	begin
		reset_n_afi_clk = 1'b0;
		repeat (3) @(posedge pll_afi_clk);
		#1 reset_n_afi_clk = 1'b1;
	end

endmodule

/* hw/read_datapath.sv */
//**************************************************************************
// Half-rate LPDDR2 read datapath on the AFI clock
// Builds the read valid strobe and the OCT window from the AFI read
// enables and reorders captured DQ data into AFI time slot order
//**************************************************************************

`timescale 1ns/1ps

`include "read_datapath_defs.svh"

module read_datapath
	import read_datapath_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,

	// Read requests from the controller and the full-burst read enable
	input  afi_phase_t afi_rdata_en_i,
	input  afi_phase_t afi_rdata_en_full_i,

	// Read latency tuned by the sequencer
	input  lat_count_t seq_read_latency_counter_i,

	// Capture data from the DDIO, already on the AFI clock
	input  afi_data_t  ddio_phy_dq_i,

	output afi_data_t  afi_rdata_o,
	output afi_phase_t afi_rdata_valid_o,
	output oct_ctrl_t  force_oct_off_o
);

	// Single-bit strobes before they fan out to the AFI buses
	logic read_valid;
	logic oct_off;

	//**********************************************************************
	// Read valid generation
	//**********************************************************************

	// In half rate the controller drives both phases of afi_rdata_en the
	// same way, so phase 0 carries the whole request
	read_valid_gen read_valid_gen_i
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (afi_rdata_en_i[0]),
		.latency_i       (seq_read_latency_counter_i),
		.read_valid_o    (read_valid)
	);

	// Data of one AFI cycle is valid on both phases at once
	assign afi_rdata_valid_o = {`AFI_RATE_RATIO{read_valid}};

	//**********************************************************************
	// OCT control
	//**********************************************************************

	// The termination window follows the full-burst enable
	// Phase 0 is enough for the same reason as above
	oct_ctrl oct_ctrl_i
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i[0]),
		.force_oct_off_o (oct_off)
	);

	// Every DQS pin and phase sees the same window
	assign force_oct_off_o = {`AFI_DQS_WIDTH{oct_off}};

	//**********************************************************************
	// Read data reordering
	//**********************************************************************

	// The FIFOs live in the I/O block, so capture data is already on the
	// AFI clock and only needs a change of bit order
	//
	// The capture bus is ordered by DQS group, then by time slot
	//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	//
	// The AFI bus is ordered by time slot, then by DQS group
	//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	//
	// Each field is one beat of one group, DQ_GROUP_WIDTH bits wide
	for (genvar g = 0; g < `MEM_READ_DQS_WIDTH; g++)
	begin : gen_dqs_group
		for (genvar t = 0; t < `NUM_TIMESLOTS; t++)
		begin : gen_timeslot
			// Beat t of group g
			dq_group_t beat;

			// Source field inside the group's block of capture data
			assign beat = ddio_phy_dq_i[`NUM_TIMESLOTS * `DQ_GROUP_WIDTH * g +
				`DQ_GROUP_WIDTH * t +: `DQ_GROUP_WIDTH];

			// Destination field inside time slot t of the AFI word
			assign afi_rdata_o[`MEM_DQ_WIDTH * t +
				`DQ_GROUP_WIDTH * g +: `DQ_GROUP_WIDTH] = beat;
		end
	end

endmodule

/* hw/oct_ctrl.sv */
//**************************************************************************
// OCT window control
// Disables output termination around the returning read burst
//**************************************************************************

`timescale 1ns/1ps

`include "read_datapath_defs.svh"

module oct_ctrl
	import read_datapath_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,

	// Full-burst read enable, phase 0 of afi_rdata_en_full
	input  logic rdata_en_full_i,

	// Low while the read burst and its preamble and postamble are on the bus
	output logic force_oct_off_o
);

	// Last OCT_OFF_DELAY read enables, bit 0 is one cycle ago
	logic [`OCT_OFF_DELAY-1:0] rdata_en_r;

	// Current enable joined to the history
	// Bit k is the enable seen k cycles ago
	logic [`OCT_OFF_DELAY:0] rdata_en_window;

	assign rdata_en_window = {rdata_en_r, rdata_en_full_i};

	//**********************************************************************
	// Enable history and window register
	//**********************************************************************

	// The burst reaches the pins MEM_T_RL memory clocks after the command
	// Taps OCT_ON_DELAY to OCT_OFF_DELAY cover it in AFI cycles
	// Requests close together merge into one window since any tap counts
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r      <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r      <= rdata_en_window[`OCT_OFF_DELAY-1:0];
			force_oct_off_o <= ~(|rdata_en_window[`OCT_OFF_DELAY:`OCT_ON_DELAY]);
		end
	end

	//**********************************************************************
	// Checks
	//**********************************************************************

	// One request keeps the window open for all taps from OCT_ON_DELAY to
	// OCT_OFF_DELAY, which is six AFI cycles at this read latency
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		$fell(force_oct_off_o) |->
			!force_oct_off_o [*(`OCT_OFF_DELAY - `OCT_ON_DELAY + 1)])
	else
		$error("OCT window shorter than the read burst");

endmodule

/* hw/read_valid_gen.sv */
//**************************************************************************
// Read valid generator
// Delays each read request by the calibrated read latency and turns it
// into the read valid strobe of the AFI
//**************************************************************************

`timescale 1ns/1ps

`include "read_datapath_defs.svh"

module read_valid_gen
	import read_datapath_pkg::*;
(
	input  logic       pll_afi_clk,
	input  logic       reset_n_afi_clk,

	// Read request, phase 0 of afi_rdata_en
	input  logic       rdata_en_i,

	// Selects which shifter stage becomes the valid strobe
	input  lat_count_t latency_i,

	output logic       read_valid_o
);

	// Request history, one bit per AFI cycle
	lat_shift_t latency_shifter;

	// Registered output of the latency tap mux
	logic tap_sel_r;

	//**********************************************************************
	// Latency shifter
	//**********************************************************************

	// A token enters stage 0 for every cycle the request is high
	// Stage L holds it L cycles later, so a burst of k requests leaves
	// k tokens in a row and gives k valid cycles
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[`MAX_READ_LATENCY-2:0], rdata_en_i};
		end
	end

	//**********************************************************************
	// Tap selection
	//**********************************************************************

	// The sequencer may change the latency at any time during calibration
	// The new value takes effect at the next edge
	// Register the 32 to 1 mux before it reaches the AFI
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			tap_sel_r    <= 1'b0;
			read_valid_o <= 1'b0;
		end
		else
		begin
			tap_sel_r    <= latency_shifter[latency_i];
			// AFI valid register, two edges after the selected stage
			read_valid_o <= tap_sel_r;
		end
	end

	//**********************************************************************
	// Checks
	//**********************************************************************

	// A rising valid must trace back to a token that sat in the shifter
	// two edges before, whatever the latency was at that time
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		$rose(read_valid_o) |-> $past(|latency_shifter, 2))
	else
		$error("read valid rose with no request in the latency shifter");

endmodule

/* hw/read_datapath_pkg.sv */
//**************************************************************************
// Read datapath types
// Vector types for AFI data, DQS group beats, latency and strobe buses
//**************************************************************************

`include "read_datapath_defs.svh"

package read_datapath_pkg;

	//**********************************************************************
	// Data buses
	//**********************************************************************

	// One AFI cycle of read data, all four time slots of every DQ pin
	typedef logic [`AFI_DATA_WIDTH-1:0] afi_data_t;

	// One beat of one DQS group as it leaves the DDIO capture
	typedef logic [`DQ_GROUP_WIDTH-1:0] dq_group_t;

	//**********************************************************************
	// Control buses
	//**********************************************************************

	// Read latency chosen by the sequencer during calibration
	// It selects a tap of the latency shifter
	typedef logic [`MAX_LATENCY_COUNT_WIDTH-1:0] lat_count_t;

	// One bit per AFI phase
	// Used for the read enables and the read valid strobe
	typedef logic [`AFI_RATE_RATIO-1:0] afi_phase_t;

	// Termination disable towards the I/O, one bit per DQS pin and phase
	typedef logic [`AFI_DQS_WIDTH-1:0] oct_ctrl_t;

	// Read request history
	// Bit 0 holds the request sampled at the last edge
	typedef logic [`MAX_READ_LATENCY-1:0] lat_shift_t;

endpackage

/* include/read_datapath_defs.svh */
//**************************************************************************
// Read datapath geometry and latency constants
// Fixes the DQ width, DQS grouping, AFI rate and the OCT window taps
//**************************************************************************

`ifndef READ_DATAPATH_DEFS_SVH
`define READ_DATAPATH_DEFS_SVH

// Memory side geometry
`define MEM_DQ_WIDTH            16
`define MEM_READ_DQS_WIDTH      2
// Each read DQS group strobes this many DQ pins
`define DQ_GROUP_WIDTH          (`MEM_DQ_WIDTH / `MEM_READ_DQS_WIDTH)

// Half-rate AFI gives two memory clocks per AFI clock
`define AFI_RATE_RATIO          2
// Two beats per memory clock, so four beats land in one AFI cycle
`define NUM_TIMESLOTS           (2 * `AFI_RATE_RATIO)
`define AFI_DATA_WIDTH          (`MEM_DQ_WIDTH * `NUM_TIMESLOTS)
// One OCT control bit per DQS pin per AFI phase
`define AFI_DQS_WIDTH           (`MEM_READ_DQS_WIDTH * `AFI_RATE_RATIO)

// Depth of the read latency shifter and width of the tap select
`define MAX_READ_LATENCY        32
`define MAX_LATENCY_COUNT_WIDTH 5

// Memory read latency in memory clocks
`define MEM_T_RL                8

// OCT window taps in AFI cycles, counted from the read enable
// The window opens early enough to cover the preamble and never goes negative
`define OCT_ON_DELAY            ((`MEM_T_RL > 4) ? ((`MEM_T_RL - 4) / 2) : 0)
// The window closes after the last beat plus the postamble
`define OCT_OFF_DELAY           ((`MEM_T_RL + 6) / 2)

`endif
